//--- hdl/dcd_pkg.sv
package dcd_pkg;

	localparam int xlen = 32;
	localparam int reg_id_w = 5;
	localparam int reg_num = 1 << reg_id_w; // architectural registers

	// funct3 codes of the supported subset
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_word = 3'b010; // lw and sw
	localparam logic [2:0] f3_mul = 3'b000;
	localparam logic [2:0] f3_mulh = 3'b001;

	// funct7 codes
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub = 7'b0100000;
	localparam logic [6:0] f7_muldiv = 7'b0000001;

	typedef enum logic [6:0] {
		opc_op = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui = 7'b0110111,
		opc_load = 7'b0000011,
		opc_store = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or = 4'd3,
		alu_xor = 4'd4,
		alu_pass_b = 4'd5 // lui and error cases
	} alu_op_e;

	typedef enum logic [1:0] {
		unit_alu = 2'd0,
		unit_lsu = 2'd1,
		unit_mul = 2'd2
	} unit_e;

	typedef enum logic [1:0] {
		err_none = 2'd0,
		err_illegal = 2'd1,
		err_fetch_bus = 2'd2
	} err_e;

endpackage

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic flush_req,
	input logic [xlen-1:0] if_inst,
	input logic [xlen-1:0] if_pc,
	input logic if_bus_err,
	input logic if_prdt_jump,
	input logic if_valid,
	output logic if_ready,
	output unit_e dec_unit,
	output alu_op_e dec_alu_op,
	output err_e dec_err,
	output logic [xlen-1:0] dec_imm,
	output logic [xlen-1:0] dec_pc,
	output logic [xlen-1:0] dec_inst,
	output logic [reg_id_w-1:0] dec_rs1_id,
	output logic [reg_id_w-1:0] dec_rs2_id,
	output logic [reg_id_w-1:0] dec_rd_id,
	output logic dec_rs1_vld,
	output logic dec_rs2_vld,
	output logic dec_rd_vld,
	output logic dec_imm_sel,
	output logic dec_ls_sel,
	output logic dec_mul_high,
	output logic dec_prdt_jump,
	output logic dec_valid,
	input logic dec_ready
);

	logic bus_err_q;
	logic legal;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign if_ready = (!dec_valid || dec_ready) && !flush_req; // no take while flushing

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (flush_req) begin
			dec_valid <= 1'b0;
		end else if (if_valid && if_ready) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (if_valid && if_ready) begin
			dec_inst <= if_inst;
			dec_pc <= if_pc;
			bus_err_q <= if_bus_err;
			dec_prdt_jump <= if_prdt_jump;
		end
	end

	assign funct3 = dec_inst[14:12];
	assign funct7 = dec_inst[31:25];
	assign dec_rs1_id = dec_inst[19:15];
	assign dec_rs2_id = dec_inst[24:20];
	assign dec_rd_id = dec_inst[11:7];

	always_comb begin
		dec_unit = unit_alu;
		dec_alu_op = alu_pass_b;
		dec_imm = '0;
		dec_imm_sel = 1'b0;
		dec_ls_sel = 1'b0;
		dec_mul_high = 1'b0;
		dec_rs1_vld = 1'b0;
		dec_rs2_vld = 1'b0;
		dec_rd_vld = 1'b0;
		legal = 1'b0;
		case (opcode_e'(dec_inst[6:0]))
			opc_op, opc_op_imm: begin
				legal = 1'b1;
				dec_rs1_vld = 1'b1;
				dec_rd_vld = 1'b1;
				dec_imm = {{20{dec_inst[31]}}, dec_inst[31:20]}; // I-type
				dec_imm_sel = (dec_inst[6:0] == opc_op_imm);
				dec_rs2_vld = !dec_imm_sel;
				case (funct3)
					f3_add_sub: dec_alu_op = alu_add;
					f3_xor: dec_alu_op = alu_xor;
					f3_or: dec_alu_op = alu_or;
					f3_and: dec_alu_op = alu_and;
					default: legal = 1'b0;
				endcase
				if (!dec_imm_sel) begin
					if (funct7 == f7_muldiv) begin
						dec_unit = unit_mul;
						dec_mul_high = (funct3 == f3_mulh);
						legal = (funct3 == f3_mul) || (funct3 == f3_mulh);
					end else if (funct7 == f7_sub && funct3 == f3_add_sub) begin
						dec_alu_op = alu_sub;
					end else if (funct7 != f7_base) begin
						legal = 1'b0;
					end
				end
			end
			opc_lui: begin
				legal = 1'b1;
				dec_rd_vld = 1'b1;
				dec_imm = {dec_inst[31:12], 12'b0};
				dec_imm_sel = 1'b1;
			end
			opc_load, opc_store: begin
				legal = (funct3 == f3_word);
				dec_unit = unit_lsu;
				dec_alu_op = alu_add; // address generation
				dec_imm_sel = 1'b1;
				dec_rs1_vld = 1'b1;
				dec_ls_sel = (dec_inst[6:0] == opc_store);
				dec_rs2_vld = dec_ls_sel; // store data
				dec_rd_vld = !dec_ls_sel;
				if (dec_ls_sel)
					dec_imm = {{20{dec_inst[31]}}, dec_inst[31:25], dec_inst[11:7]};
				else
					dec_imm = {{20{dec_inst[31]}}, dec_inst[31:20]};
			end
			default: ;
		endcase
		// bus error wins over any decode result
		if (bus_err_q || !legal) begin
			dec_unit = unit_alu;
			dec_alu_op = alu_pass_b;
			dec_rs1_vld = 1'b0;
			dec_rs2_vld = 1'b0;
			dec_rd_vld = 1'b0;
		end
	end

	assign dec_err = bus_err_q ? err_fetch_bus : (legal ? err_none : err_illegal);

	// held message stays put under back-pressure
	a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid && !dec_ready && !flush_req |=>
			dec_valid && $stable(dec_inst) && $stable(dec_pc));

endmodule

//--- hdl/reg_file_rd.sv
`timescale 1ns/1ps

module reg_file_rd import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic flush_req,
	input unit_e dec_unit,
	input alu_op_e dec_alu_op,
	input err_e dec_err,
	input logic [xlen-1:0] dec_imm,
	input logic [xlen-1:0] dec_pc,
	input logic [xlen-1:0] dec_inst,
	input logic [reg_id_w-1:0] dec_rs1_id,
	input logic [reg_id_w-1:0] dec_rs2_id,
	input logic [reg_id_w-1:0] dec_rd_id,
	input logic dec_rs1_vld,
	input logic dec_rs2_vld,
	input logic dec_rd_vld,
	input logic dec_imm_sel,
	input logic dec_ls_sel,
	input logic dec_mul_high,
	input logic dec_prdt_jump,
	input logic dec_valid,
	output logic dec_ready,
	output logic [reg_id_w-1:0] raw_rs1_id,
	output logic [reg_id_w-1:0] raw_rs2_id,
	input logic rs1_raw,
	input logic rs2_raw,
	output logic rd_p0_req,
	output logic [reg_id_w-1:0] rd_p0_addr,
	input logic rd_p0_grant,
	input logic [xlen-1:0] rd_p0_dout,
	output logic rd_p1_req,
	output logic [reg_id_w-1:0] rd_p1_addr,
	input logic rd_p1_grant,
	input logic [xlen-1:0] rd_p1_dout,
	output logic [xlen-1:0] opr_rs1_v,
	output logic [xlen-1:0] opr_rs2_v,
	output unit_e opr_unit,
	output alu_op_e opr_alu_op,
	output err_e opr_err,
	output logic [xlen-1:0] opr_imm,
	output logic [xlen-1:0] opr_pc,
	output logic [xlen-1:0] opr_inst,
	output logic [reg_id_w-1:0] opr_rd_id,
	output logic opr_rd_vld,
	output logic opr_imm_sel,
	output logic opr_ls_sel,
	output logic opr_mul_high,
	output logic opr_prdt_jump,
	output logic opr_valid,
	input logic opr_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_raw,
		st_wait_grant,
		st_full
	} rd_state_e;

	rd_state_e state;
	logic [reg_id_w-1:0] rs1_id_q;
	logic [reg_id_w-1:0] rs2_id_q;
	logic rs1_vld_q;
	logic rs2_vld_q;
	logic p0_wait;
	logic p1_wait;
	logic raw_stall;
	logic grants_done;

	assign dec_ready = (state == st_idle);
	assign opr_valid = (state == st_full) && !flush_req;

	assign raw_rs1_id = rs1_id_q;
	assign raw_rs2_id = rs2_id_q;
	assign raw_stall = (rs1_vld_q && rs1_raw) || (rs2_vld_q && rs2_raw);

	// one-cycle request, only for the sources in use
	assign rd_p0_req = (state == st_wait_raw) && !raw_stall && rs1_vld_q;
	assign rd_p1_req = (state == st_wait_raw) && !raw_stall && rs2_vld_q;
	assign rd_p0_addr = rs1_id_q;
	assign rd_p1_addr = rs2_id_q;

	assign grants_done = (!p0_wait || rd_p0_grant) && (!p1_wait || rd_p1_grant);

	always_ff @(posedge clk) begin
		if (!rst_n || flush_req) begin
			state <= st_idle;
			p0_wait <= 1'b0;
			p1_wait <= 1'b0;
		end else begin
			case (state)
				st_idle: if (dec_valid) state <= st_wait_raw;
				st_wait_raw: begin
					if (!raw_stall) begin
						p0_wait <= rs1_vld_q;
						p1_wait <= rs2_vld_q;
						state <= (rs1_vld_q || rs2_vld_q) ? st_wait_grant : st_full;
					end
				end
				st_wait_grant: begin
					if (rd_p0_grant) p0_wait <= 1'b0;
					if (rd_p1_grant) p1_wait <= 1'b0;
					if (grants_done) state <= st_full;
				end
				st_full: if (opr_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && dec_valid) begin
			rs1_id_q <= dec_rs1_id;
			rs2_id_q <= dec_rs2_id;
			rs1_vld_q <= dec_rs1_vld;
			rs2_vld_q <= dec_rs2_vld;
			opr_unit <= dec_unit;
			opr_alu_op <= dec_alu_op;
			opr_err <= dec_err;
			opr_imm <= dec_imm;
			opr_pc <= dec_pc;
			opr_inst <= dec_inst;
			opr_rd_id <= dec_rd_id;
			opr_rd_vld <= dec_rd_vld;
			opr_imm_sel <= dec_imm_sel;
			opr_ls_sel <= dec_ls_sel;
			opr_mul_high <= dec_mul_high;
			opr_prdt_jump <= dec_prdt_jump;
			opr_rs1_v <= '0; // unused source reads as zero
			opr_rs2_v <= '0;
		end
		if (p0_wait && rd_p0_grant) opr_rs1_v <= rd_p0_dout;
		if (p1_wait && rd_p1_grant) opr_rs2_v <= rd_p1_dout;
	end

	// a requested source stays settled until its data returns
	a_src_settled: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_p0_req |=> !rs1_raw) and (rd_p1_req |=> !rs2_raw));

	// register file answers every request on the next cycle
	a_grant_follows: assert property (@(posedge clk) disable iff (!rst_n)
		rd_p0_req |=> rd_p0_grant);

endmodule

//--- hdl/dispatcher.sv
`timescale 1ns/1ps

module dispatcher import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [xlen-1:0] opr_rs1_v,
	input logic [xlen-1:0] opr_rs2_v,
	input unit_e opr_unit,
	input alu_op_e opr_alu_op,
	input err_e opr_err,
	input logic [xlen-1:0] opr_imm,
	input logic [xlen-1:0] opr_pc,
	input logic [xlen-1:0] opr_inst,
	input logic [reg_id_w-1:0] opr_rd_id,
	input logic opr_rd_vld,
	input logic opr_imm_sel,
	input logic opr_ls_sel,
	input logic opr_mul_high,
	input logic opr_prdt_jump,
	input logic opr_valid,
	output logic opr_ready,
	output logic [reg_id_w-1:0] waw_rd_id,
	input logic rd_waw,
	output logic dsp_set_valid,
	output logic [reg_id_w-1:0] dsp_set_rd,
	output alu_op_e alu_op_mode,
	output logic [xlen-1:0] alu_op1,
	output logic [xlen-1:0] alu_op2,
	output err_e alu_err_code,
	output logic [xlen-1:0] alu_pc,
	output logic alu_prdt_jump,
	output logic [reg_id_w-1:0] alu_rd_id,
	output logic alu_rd_vld,
	output logic alu_addr_gen,
	output logic alu_valid,
	input logic alu_ready,
	output logic ls_sel,
	output logic [reg_id_w-1:0] ls_rd_id,
	output logic [xlen-1:0] ls_din,
	output logic lsu_valid,
	input logic lsu_ready,
	output logic [xlen-1:0] mul_op_a,
	output logic [xlen-1:0] mul_op_b,
	output logic mul_high_sel,
	output logic [reg_id_w-1:0] mul_rd_id,
	output logic mul_valid,
	input logic mul_ready
);

	logic waw_stall;
	logic go;
	logic is_lsu;
	logic is_mul;

	assign waw_rd_id = opr_rd_id;
	assign waw_stall = opr_rd_vld && rd_waw; // earlier write to rd still outstanding
	assign go = opr_valid && !waw_stall;
	assign is_lsu = (opr_unit == unit_lsu);
	assign is_mul = (opr_unit == unit_mul);

	// load/store needs both units ready in the same cycle
	always_comb begin
		if (waw_stall)
			opr_ready = 1'b0;
		else if (is_mul)
			opr_ready = mul_ready;
		else if (is_lsu)
			opr_ready = alu_ready && lsu_ready;
		else
			opr_ready = alu_ready;
	end

	assign alu_valid = go && !is_mul;
	assign lsu_valid = go && is_lsu;
	assign mul_valid = go && is_mul;

	assign alu_op_mode = opr_alu_op;
	assign alu_op1 = opr_rs1_v;
	assign alu_op2 = (opr_err != err_none) ? opr_inst : (opr_imm_sel ? opr_imm : opr_rs2_v);
	assign alu_err_code = opr_err;
	assign alu_pc = opr_pc;
	assign alu_prdt_jump = opr_prdt_jump;
	assign alu_rd_id = opr_rd_id;
	assign alu_rd_vld = opr_rd_vld && !is_lsu; // lsu owns the load result
	assign alu_addr_gen = is_lsu;

	assign ls_sel = opr_ls_sel;
	assign ls_rd_id = opr_rd_id;
	assign ls_din = opr_rs2_v;

	assign mul_op_a = opr_rs1_v;
	assign mul_op_b = opr_rs2_v;
	assign mul_high_sel = opr_mul_high;
	assign mul_rd_id = opr_rd_id;

	assign dsp_set_valid = opr_valid && opr_ready && opr_rd_vld;
	assign dsp_set_rd = opr_rd_id;

	// held operands stay put while the request waits
	a_opr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		opr_valid && !opr_ready |=>
			$stable(opr_rs1_v) && $stable(opr_rs2_v) && $stable(opr_inst));

endmodule

//--- hdl/dcd_dsptc.sv
`timescale 1ns/1ps

module dcd_dsptc import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic flush_req,
	input logic [xlen-1:0] if_inst,
	input logic [xlen-1:0] if_pc,
	input logic if_bus_err,
	input logic if_prdt_jump,
	input logic if_valid,
	output logic if_ready,
	output logic [reg_id_w-1:0] raw_rs1_id,
	output logic [reg_id_w-1:0] raw_rs2_id,
	input logic rs1_raw,
	input logic rs2_raw,
	output logic [reg_id_w-1:0] waw_rd_id,
	input logic rd_waw,
	output logic dsp_set_valid,
	output logic [reg_id_w-1:0] dsp_set_rd,
	output logic rd_p0_req,
	output logic [reg_id_w-1:0] rd_p0_addr,
	input logic rd_p0_grant,
	input logic [xlen-1:0] rd_p0_dout,
	output logic rd_p1_req,
	output logic [reg_id_w-1:0] rd_p1_addr,
	input logic rd_p1_grant,
	input logic [xlen-1:0] rd_p1_dout,
	output alu_op_e alu_op_mode,
	output logic [xlen-1:0] alu_op1,
	output logic [xlen-1:0] alu_op2,
	output err_e alu_err_code,
	output logic [xlen-1:0] alu_pc,
	output logic alu_prdt_jump,
	output logic [reg_id_w-1:0] alu_rd_id,
	output logic alu_rd_vld,
	output logic alu_addr_gen,
	output logic alu_valid,
	input logic alu_ready,
	output logic ls_sel,
	output logic [reg_id_w-1:0] ls_rd_id,
	output logic [xlen-1:0] ls_din,
	output logic lsu_valid,
	input logic lsu_ready,
	output logic [xlen-1:0] mul_op_a,
	output logic [xlen-1:0] mul_op_b,
	output logic mul_high_sel,
	output logic [reg_id_w-1:0] mul_rd_id,
	output logic mul_valid,
	input logic mul_ready
);

	// decoder to read control
	unit_e dec_unit;
	alu_op_e dec_alu_op;
	err_e dec_err;
	logic [xlen-1:0] dec_imm, dec_pc, dec_inst;
	logic [reg_id_w-1:0] dec_rs1_id, dec_rs2_id, dec_rd_id;
	logic dec_rs1_vld, dec_rs2_vld, dec_rd_vld;
	logic dec_imm_sel, dec_ls_sel, dec_mul_high, dec_prdt_jump;
	logic dec_valid, dec_ready;

	// read control to dispatcher
	unit_e opr_unit;
	alu_op_e opr_alu_op;
	err_e opr_err;
	logic [xlen-1:0] opr_rs1_v, opr_rs2_v;
	logic [xlen-1:0] opr_imm, opr_pc, opr_inst;
	logic [reg_id_w-1:0] opr_rd_id;
	logic opr_rd_vld, opr_imm_sel, opr_ls_sel, opr_mul_high, opr_prdt_jump;
	logic opr_valid, opr_ready;

	inst_decoder u_inst_decoder (.*);

	reg_file_rd u_reg_file_rd (.*);

	dispatcher u_dispatcher (.*);

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rd_p0_req,
	input logic [reg_id_w-1:0] rd_p0_addr,
	output logic rd_p0_grant,
	output logic [xlen-1:0] rd_p0_dout,
	input logic rd_p1_req,
	input logic [reg_id_w-1:0] rd_p1_addr,
	output logic rd_p1_grant,
	output logic [xlen-1:0] rd_p1_dout,
	input logic wb_valid,
	input logic [reg_id_w-1:0] wb_rd_id,
	input logic [xlen-1:0] wb_data
);

	logic [xlen-1:0] regs [reg_num];

	// read value with same-edge writeback forwarded, x0 hardwired
	function automatic logic [xlen-1:0] rd_val(input logic [reg_id_w-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb_valid && wb_rd_id == addr)
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wb_valid && wb_rd_id != '0) regs[wb_rd_id] <= wb_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_p0_grant <= 1'b0;
			rd_p1_grant <= 1'b0;
		end else begin
			rd_p0_grant <= rd_p0_req;
			rd_p1_grant <= rd_p1_req;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_p0_req) rd_p0_dout <= rd_val(rd_p0_addr);
		if (rd_p1_req) rd_p1_dout <= rd_val(rd_p1_addr);
	end

endmodule

//--- hdl/scoreboard.sv
`timescale 1ns/1ps

module scoreboard import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [reg_id_w-1:0] raw_rs1_id,
	input logic [reg_id_w-1:0] raw_rs2_id,
	input logic [reg_id_w-1:0] waw_rd_id,
	output logic rs1_raw,
	output logic rs2_raw,
	output logic rd_waw,
	input logic dsp_set_valid,
	input logic [reg_id_w-1:0] dsp_set_rd,
	input logic wb_valid,
	input logic [reg_id_w-1:0] wb_rd_id
);

	logic [reg_num-1:0] pending; // one bit per register

	assign rs1_raw = pending[raw_rs1_id];
	assign rs2_raw = pending[raw_rs2_id];
	assign rd_waw = pending[waw_rd_id];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			if (wb_valid)
				pending[wb_rd_id] <= 1'b0;
			// set after clear, a new producer wins
			if (dsp_set_valid && dsp_set_rd != '0)
				pending[dsp_set_rd] <= 1'b1;
		end
	end

	// writeback must match a dispatched producer
	a_wb_pending: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid && wb_rd_id != '0 |-> pending[wb_rd_id]);

endmodule

//--- hdl/dcd_top.sv
`timescale 1ns/1ps

module dcd_top import dcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic flush_req,
	input logic [xlen-1:0] if_inst,
	input logic [xlen-1:0] if_pc,
	input logic if_bus_err,
	input logic if_prdt_jump,
	input logic if_valid,
	output logic if_ready,
	output alu_op_e alu_op_mode,
	output logic [xlen-1:0] alu_op1,
	output logic [xlen-1:0] alu_op2,
	output err_e alu_err_code,
	output logic [xlen-1:0] alu_pc,
	output logic alu_prdt_jump,
	output logic [reg_id_w-1:0] alu_rd_id,
	output logic alu_rd_vld,
	output logic alu_addr_gen,
	output logic alu_valid,
	input logic alu_ready,
	output logic ls_sel,
	output logic [reg_id_w-1:0] ls_rd_id,
	output logic [xlen-1:0] ls_din,
	output logic lsu_valid,
	input logic lsu_ready,
	output logic [xlen-1:0] mul_op_a,
	output logic [xlen-1:0] mul_op_b,
	output logic mul_high_sel,
	output logic [reg_id_w-1:0] mul_rd_id,
	output logic mul_valid,
	input logic mul_ready,
	input logic wb_valid,
	input logic [reg_id_w-1:0] wb_rd_id,
	input logic [xlen-1:0] wb_data
);

	logic rd_p0_req, rd_p0_grant;
	logic rd_p1_req, rd_p1_grant;
	logic [reg_id_w-1:0] rd_p0_addr, rd_p1_addr;
	logic [xlen-1:0] rd_p0_dout, rd_p1_dout;
	logic [reg_id_w-1:0] raw_rs1_id, raw_rs2_id, waw_rd_id;
	logic rs1_raw, rs2_raw, rd_waw;
	logic dsp_set_valid;
	logic [reg_id_w-1:0] dsp_set_rd;

	dcd_dsptc u_dcd_dsptc (.*);

	reg_file u_reg_file (.*);

	scoreboard u_scoreboard (.*);

endmodule

//--- dv/tb_dcd_top.sv
`timescale 1ns/1ps

module tb_dcd_top import dcd_pkg::*; ();

	typedef struct packed {
		unit_e unit;
		alu_op_e op;
		err_e err;
		logic [xlen-1:0] op1;
		logic [xlen-1:0] op2;
		logic [xlen-1:0] din;
		logic [xlen-1:0] res;
		logic [xlen-1:0] pc;
		logic [reg_id_w-1:0] rd;
		logic rd_vld;
		logic alu_wr;
		logic mulh;
		logic pj;
		logic st;
	} exp_t;

	localparam int n_rand = 300;

	logic clk, rst_n, flush_req;
	logic [xlen-1:0] if_inst, if_pc;
	logic if_bus_err, if_prdt_jump, if_valid, if_ready;
	alu_op_e alu_op_mode;
	logic [xlen-1:0] alu_op1, alu_op2, alu_pc;
	err_e alu_err_code;
	logic alu_prdt_jump, alu_rd_vld, alu_addr_gen, alu_valid, alu_ready;
	logic [reg_id_w-1:0] alu_rd_id, ls_rd_id, mul_rd_id, wb_rd_id;
	logic ls_sel, lsu_valid, lsu_ready;
	logic [xlen-1:0] ls_din, mul_op_a, mul_op_b, wb_data;
	logic mul_high_sel, mul_valid, mul_ready, wb_valid;

	exp_t exp_q[$]; // expected dispatches in program order
	exp_t exp_head;
	logic exp_vld;
	logic [xlen-1:0] shadow [reg_num];
	logic [reg_num-1:0] owed; // writebacks not yet delivered
	int wb_due[$];
	logic [reg_id_w-1:0] wb_rd_q[$];
	logic [xlen-1:0] wb_dat_q[$];
	int cycles, n_sent;
	logic hold, fire_alu, fire_mul;
	logic [xlen-1:0] pc;
	string test_name;

	dcd_top u_dcd_top (.*);

	always #20 clk = ~clk;

	task automatic fail_value(input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("ERROR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
		$display("Simulation FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic fail_msg(input string msg);
		$display("%s during %s", msg, test_name);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] alu_calc(input alu_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or: return a | b;
			alu_xor: return a ^ b;
			default: return b;
		endcase
	endfunction

	a_alu_match: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> exp_vld && exp_head.unit != unit_mul)
		else fail_msg("ALU request without a matching instruction");
	a_alu_mode: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_op_mode == exp_head.op)
		else fail_value("alu_op_mode", 32'(exp_head.op), 32'($sampled(alu_op_mode)));
	a_alu_op1: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_op1 == exp_head.op1)
		else fail_value("alu_op1", exp_head.op1, $sampled(alu_op1));
	a_alu_op2: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_op2 == exp_head.op2)
		else fail_value("alu_op2", exp_head.op2, $sampled(alu_op2));
	a_alu_err: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_err_code == exp_head.err)
		else fail_value("alu_err_code", 32'(exp_head.err), 32'($sampled(alu_err_code)));
	a_alu_pc: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_pc == exp_head.pc)
		else fail_value("alu_pc", exp_head.pc, $sampled(alu_pc));
	a_alu_pj: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_prdt_jump == exp_head.pj)
		else fail_value("alu_prdt_jump", 32'(exp_head.pj), 32'($sampled(alu_prdt_jump)));
	a_alu_rd_vld: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready |-> alu_rd_vld == exp_head.alu_wr)
		else fail_value("alu_rd_vld", 32'(exp_head.alu_wr), 32'($sampled(alu_rd_vld)));
	a_alu_rd_id: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && alu_ready && exp_head.alu_wr |-> alu_rd_id == exp_head.rd)
		else fail_value("alu_rd_id", 32'(exp_head.rd), 32'($sampled(alu_rd_id)));
	a_ls_pair: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_valid == (alu_valid && alu_addr_gen))
		else fail_msg("LSU and address requests did not rise together");
	a_ls_unit: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_valid && lsu_ready |-> exp_vld && exp_head.unit == unit_lsu)
		else fail_msg("LSU request for a non memory instruction");
	a_ls_sel: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_valid && lsu_ready |-> ls_sel == exp_head.st)
		else fail_value("ls_sel", 32'(exp_head.st), 32'($sampled(ls_sel)));
	a_ls_din: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_valid && lsu_ready && exp_head.st |-> ls_din == exp_head.din)
		else fail_value("ls_din", exp_head.din, $sampled(ls_din));
	a_ls_rd: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_valid && lsu_ready && !exp_head.st |-> ls_rd_id == exp_head.rd)
		else fail_value("ls_rd_id", 32'(exp_head.rd), 32'($sampled(ls_rd_id)));
	a_mul_match: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid && mul_ready |-> exp_vld && exp_head.unit == unit_mul)
		else fail_msg("multiplier request without a matching instruction");
	a_mul_a: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid && mul_ready |-> mul_op_a == exp_head.op1)
		else fail_value("mul_op_a", exp_head.op1, $sampled(mul_op_a));
	a_mul_b: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid && mul_ready |-> mul_op_b == exp_head.op2)
		else fail_value("mul_op_b", exp_head.op2, $sampled(mul_op_b));
	a_mul_high: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid && mul_ready |-> mul_high_sel == exp_head.mulh)
		else fail_value("mul_high_sel", 32'(exp_head.mulh), 32'($sampled(mul_high_sel)));
	a_mul_rd: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid && mul_ready |-> mul_rd_id == exp_head.rd)
		else fail_value("mul_rd_id", 32'(exp_head.rd), 32'($sampled(mul_rd_id)));
	a_no_waw: assert property (@(posedge clk) disable iff (!rst_n)
		(alu_valid && alu_ready) || (mul_valid && mul_ready) |->
			!(exp_head.rd_vld && owed[exp_head.rd]))
		else fail_msg("dispatch to a register with an outstanding writeback");

	// transfers are settled mid cycle, inputs only move after the edge
	always @(negedge clk) begin
		fire_alu = alu_valid && alu_ready;
		fire_mul = mul_valid && mul_ready;
	end

	// unit models, writeback and ready patterns
	always @(posedge clk) begin
		exp_t e;
		int pick;
		#2;
		cycles++;
		if (cycles > 20 * n_sent + 200)
			fail_msg("timeout waiting for the pipeline to drain");
		if (rst_n && (fire_alu || fire_mul)) begin
			e = exp_q.pop_front();
			if (e.rd_vld && e.rd != '0) begin
				owed[e.rd] = 1'b1;
				wb_due.push_back(cycles + 1 + $urandom_range(5)); // 1 to 6 cycles
				wb_rd_q.push_back(e.rd);
				wb_dat_q.push_back(e.res);
			end
		end
		wb_valid = 1'b0;
		pick = -1;
		foreach (wb_due[i])
			if (pick < 0 && wb_due[i] <= cycles) pick = i;
		if (pick >= 0) begin
			wb_valid = 1'b1;
			wb_rd_id = wb_rd_q[pick];
			wb_data = wb_dat_q[pick];
			owed[wb_rd_id] = 1'b0;
			wb_due.delete(pick);
			wb_rd_q.delete(pick);
			wb_dat_q.delete(pick);
		end
		alu_ready = !hold && ($urandom_range(99) < 70);
		lsu_ready = alu_ready; // tied in this model only
		mul_ready = !hold && ($urandom_range(99) < 60);
		exp_vld <= (exp_q.size() > 0);
		if (exp_q.size() > 0) exp_head <= exp_q[0];
	end

	// kind 0 reg alu, 1 imm alu, 2 lui, 3 lw, 4 sw, 5 mul, 6 illegal, 7 bus error
	task automatic issue(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic keep);
		logic [31:0] inst, a, b, imm, r;
		logic [2:0] f3;
		logic bus;
		exp_t e;
		longint p;
		a = shadow[rs1];
		b = shadow[rs2];
		r = $urandom;
		imm = {{20{r[11]}}, r[11:0]};
		bus = 1'b0;
		e = '0;
		e.unit = unit_alu;
		e.op = alu_pass_b;
		e.err = err_none;
		e.rd = rd;
		case (kind)
			0, 1: begin
				case ((kind == 0) ? $urandom_range(4) : $urandom_range(3))
					0: begin e.op = alu_add; f3 = 3'b000; end
					1: begin e.op = alu_xor; f3 = 3'b100; end
					2: begin e.op = alu_or; f3 = 3'b110; end
					3: begin e.op = alu_and; f3 = 3'b111; end
					default: begin e.op = alu_sub; f3 = 3'b000; end
				endcase
				e.op1 = a;
				e.op2 = (kind == 0) ? b : imm;
				if (kind == 0)
					inst = {(e.op == alu_sub) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, 7'b0110011};
				else
					inst = {imm[11:0], rs1, f3, rd, 7'b0010011};
				e.res = alu_calc(e.op, e.op1, e.op2);
				e.rd_vld = 1'b1;
				e.alu_wr = 1'b1;
			end
			2: begin
				inst = {r[31:12], rd, 7'b0110111};
				e.op2 = {r[31:12], 12'b0};
				e.res = e.op2;
				e.rd_vld = 1'b1;
				e.alu_wr = 1'b1;
			end
			3, 4: begin
				e.unit = unit_lsu;
				e.op = alu_add; // address is rs1 plus offset
				e.op1 = a;
				e.op2 = imm;
				if (kind == 3) begin
					inst = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
					e.res = $urandom; // load data from the memory model
					e.rd_vld = 1'b1;
				end else begin
					inst = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
					e.din = b;
					e.rd = imm[4:0];
					e.st = 1'b1;
				end
			end
			5: begin
				e.unit = unit_mul;
				e.mulh = r[0];
				inst = {7'b0000001, rs2, rs1, {2'b00, r[0]}, rd, 7'b0110011};
				e.op1 = a;
				e.op2 = b;
				p = longint'($signed(a)) * longint'($signed(b));
				e.res = r[0] ? p[63:32] : p[31:0];
				e.rd_vld = 1'b1;
			end
			6: begin
				inst = {r[31:7], 7'b1110011}; // system opcode is outside the subset
				e.err = err_illegal;
				e.op2 = inst;
			end
			default: begin
				inst = r;
				bus = 1'b1;
				e.err = err_fetch_bus;
				e.op2 = inst;
			end
		endcase
		e.pc = pc;
		e.pj = ($urandom_range(1) == 1);
		if (keep) begin
			exp_q.push_back(e);
			if (e.rd_vld && rd != '0) shadow[rd] = e.res;
		end
		n_sent++;
		if_inst = inst;
		if_bus_err = bus;
		if_pc = pc;
		if_prdt_jump = e.pj;
		if_valid = 1'b1;
		@(negedge clk);
		while (!if_ready) @(negedge clk);
		@(posedge clk);
		#2;
		if_valid = 1'b0;
		pc = pc + 4;
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || wb_due.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		#2;
	endtask

	initial begin
		int k;
		void'($urandom(32'haa5e6194));
		clk = 1'b0;
		rst_n = 1'b0;
		flush_req = 1'b0;
		{if_inst, if_pc, if_bus_err, if_prdt_jump, if_valid} = '0;
		{alu_ready, lsu_ready, mul_ready} = '0;
		{wb_valid, wb_rd_id, wb_data} = '0;
		{hold, fire_alu, fire_mul, exp_vld, owed} = '0;
		exp_head = '0;
		cycles = 0;
		n_sent = 0;
		pc = 32'h0000_1000;
		test_name = "reset";
		foreach (shadow[i]) shadow[i] = '0;
		repeat (2) @(posedge clk);
		#2 rst_n = 1'b1;
		test_name = "register init";
		for (int r = 1; r < 8; r++) issue(2, r, 0, 0, 1'b1);
		test_name = "random mix";
		repeat (n_rand) begin
			k = $urandom_range(15);
			issue((k > 7) ? k % 6 : k, $urandom_range(7), $urandom_range(7),
				$urandom_range(7), 1'b1);
		end
		test_name = "dependences";
		repeat (8) issue(0, 3, 3, 3, 1'b1);
		repeat (4) issue(5, 3, 3, 3, 1'b1);
		test_name = "errors";
		repeat (2) issue(6, 0, 0, 0, 1'b1);
		repeat (2) issue(7, 0, 0, 0, 1'b1);
		test_name = "flush";
		drain();
		hold = 1'b1;
		@(posedge clk);
		#2;
		issue(1, 4, 1, 2, 1'b0); // dropped by the flush
		issue(0, 5, 4, 4, 1'b0);
		flush_req = 1'b1;
		@(posedge clk);
		#2 flush_req = 1'b0;
		hold = 1'b0;
		issue(0, 6, 4, 5, 1'b1);
		repeat (4) issue($urandom_range(5), $urandom_range(7), $urandom_range(7),
			$urandom_range(7), 1'b1);
		drain();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- all.f
hdl/dcd_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file_rd.sv
hdl/dispatcher.sv
hdl/dcd_dsptc.sv
hdl/reg_file.sv
hdl/scoreboard.sv
hdl/dcd_top.sv
dv/tb_dcd_top.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcd_top \
	-f all.f -o tb_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Simulation PASSED" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
